// ==== design/gpio_port.sv ====
//------------------------------------------------
// Digital port 1
// Output and direction registers, pin sync,
// edge detect, interrupt flags and enables
//------------------------------------------------
module gpio_port #(
  parameter logic [15:0] BASE_ADDR = per_map_pkg::GPIO_BASE_DEF
) (
  input  logic                       mclk,
  input  logic                       arst_n,
  input  logic [per_map_pkg::AW-1:0] per_addr,
  input  logic [per_map_pkg::DW-1:0] per_din,
  input  logic                       per_en,
  input  logic [1:0]                 per_we,
  output logic [per_map_pkg::DW-1:0] per_dout,
  input  logic [7:0]                 p1_din,
  output logic [7:0]                 p1_dout,
  output logic [7:0]                 p1_dout_en,
  output logic                       irq_port1
);

  per_map_pkg::per_word_u din_u;
  logic       hit_in_out;
  logic       hit_dir_ifg;
  logic       hit_ies_ie;
  logic [1:0] wr_in_out;
  logic [1:0] wr_dir_ifg;
  logic [1:0] wr_ies_ie;
  logic       rd_en;
  logic [7:0] p1out;
  logic [7:0] p1dir;
  logic [7:0] p1ifg;
  logic [7:0] p1ies;
  logic [7:0] p1ie;
  logic [7:0] sync1;
  logic [7:0] sync2;
  logic [7:0] p1in;                              // P1IN register value
  logic [7:0] p1in_d;                            // Previous P1IN for edge detect
  logic [7:0] pin_edge;

  assign din_u.word  = per_din;
  assign hit_in_out  = per_map_pkg::reg_hit(per_addr, BASE_ADDR, per_map_pkg::OFS_P1IN_OUT);
  assign hit_dir_ifg = per_map_pkg::reg_hit(per_addr, BASE_ADDR, per_map_pkg::OFS_P1DIR_IFG);
  assign hit_ies_ie  = per_map_pkg::reg_hit(per_addr, BASE_ADDR, per_map_pkg::OFS_P1IES_IE);
  assign wr_in_out   = per_we & {2{per_en & hit_in_out}};
  assign wr_dir_ifg  = per_we & {2{per_en & hit_dir_ifg}};
  assign wr_ies_ie   = per_we & {2{per_en & hit_ies_ie}};
  assign rd_en       = per_en & (per_we == 2'b00);

  // Rising edge when IES is 0, falling when 1
  assign pin_edge = (p1in & ~p1in_d & ~p1ies) | (~p1in & p1in_d & p1ies);

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      sync1  <= '0;
      sync2  <= '0;
      p1in   <= '0;
      p1in_d <= '0;
      p1out  <= '0;
      p1dir  <= '0;
      p1ifg  <= '0;
      p1ies  <= '0;
      p1ie   <= '0;
    end else begin
      sync1  <= p1_din;                          // Two-flop synchronizer
      sync2  <= sync1;
      p1in   <= sync2;
      p1in_d <= p1in;
      if (wr_in_out[1]) p1out <= din_u.lane.hi;  // P1IN lane is read only
      if (wr_dir_ifg[0]) p1dir <= din_u.lane.lo;
      p1ifg  <= (wr_dir_ifg[1] ? din_u.lane.hi : p1ifg) | pin_edge; // Edge wins
      if (wr_ies_ie[0]) p1ies <= din_u.lane.lo;
      if (wr_ies_ie[1]) p1ie <= din_u.lane.hi;
    end
  end

  assign p1_dout    = p1out;
  assign p1_dout_en = p1dir;
  assign irq_port1  = |(p1ifg & p1ie);

  always_comb begin
    per_dout = '0;
    if (rd_en && hit_in_out) per_dout = {p1out, p1in};
    if (rd_en && hit_dir_ifg) per_dout = {p1ifg, p1dir};
    if (rd_en && hit_ies_ie) per_dout = {p1ie, p1ies};
  end

  // A new flag bit needs a pin edge or a write to the IFG lane
  a_ifg_source : assert property (@(posedge mclk) disable iff (!arst_n)
    ((p1ifg & ~$past(p1ifg) & ~$past(pin_edge)) != 8'h00) |-> $past(wr_dir_ifg[1]));

endmodule

// ==== design/irq_pkg.sv ====
//------------------------------------------------
// Interrupt vector map
// Vector width and per-source vector numbers
//------------------------------------------------
package irq_pkg;

  localparam int IRQ_W = 14;                       // Maskable vector width

  localparam int VEC_PORT1   = 2;                  // 0xFFE4
  localparam int VEC_UART_TX = 6;                  // 0xFFEC
  localparam int VEC_TA1     = 8;                  // 0xFFF0, TAIFG
  localparam int VEC_TA0     = 9;                  // 0xFFF2, CCIFG0

endpackage

// ==== design/per_map_pkg.sv ====
//------------------------------------------------
// Peripheral bus map
// Bus widths, data-word union, base addresses,
// register offsets, Timer A fields, address match
//------------------------------------------------
package per_map_pkg;

  localparam int AW = 14;                          // Word address width
  localparam int DW = 16;                          // Data width

  // One bus word, read whole or as two byte lanes
  typedef union packed {
    logic [DW-1:0] word;
    struct packed {
      logic [7:0] hi;                              // Lane of per_we[1]
      logic [7:0] lo;                              // Lane of per_we[0]
    } lane;
  } per_word_u;

  localparam logic [15:0] GPIO_BASE_DEF = 16'h0020; // Byte addresses
  localparam logic [15:0] TA_BASE_DEF   = 16'h0160;
  localparam logic [15:0] UART_BASE_DEF = 16'h0080;

  //------------------------------------------------
  // Register byte offsets
  //------------------------------------------------
  localparam logic [15:0] OFS_P1IN_OUT  = 16'd0;   // P1IN lo, P1OUT hi
  localparam logic [15:0] OFS_P1DIR_IFG = 16'd2;   // P1DIR lo, P1IFG hi
  localparam logic [15:0] OFS_P1IES_IE  = 16'd4;   // P1IES lo, P1IE hi
  localparam logic [15:0] OFS_TACTL     = 16'd0;
  localparam logic [15:0] OFS_TACCTL0   = 16'd2;
  localparam logic [15:0] OFS_TAR       = 16'd16;
  localparam logic [15:0] OFS_TACCR0    = 16'd18;
  localparam logic [15:0] OFS_UCTL_STAT = 16'd0;   // Control lo, status hi
  localparam logic [15:0] OFS_UBAUD     = 16'd2;
  localparam logic [15:0] OFS_UTXD      = 16'd4;

  // Timer A bit positions
  localparam int MC_UP  = 4;                       // TACTL
  localparam int TACLR  = 2;
  localparam int TAIE   = 1;
  localparam int TAIFG  = 0;
  localparam int ID_LSB = 6;                       // ID at 7:6
  localparam int CCIE   = 4;                       // TACCTL0
  localparam int CCIFG  = 0;

  // Word address compare against base plus byte offset
  function automatic logic reg_hit(input logic [AW-1:0] addr, input logic [15:0] base,
                                   input logic [15:0] ofs);
    logic [15:0] byte_addr;
    byte_addr = base + ofs;
    return addr == byte_addr[AW:1];
  endfunction

endpackage

// ==== design/periph_top.sv ====
//------------------------------------------------
// Peripheral subsystem top
// Port 1, Timer A and UART TX instances,
// read-bus OR and interrupt vector map
//------------------------------------------------
module periph_top #(
  parameter logic [15:0] GPIO_BASE = per_map_pkg::GPIO_BASE_DEF,
  parameter logic [15:0] TA_BASE   = per_map_pkg::TA_BASE_DEF,
  parameter logic [15:0] UART_BASE = per_map_pkg::UART_BASE_DEF,
  parameter logic [15:0] RST_BAUD  = 16'd7
) (
  input  logic                       mclk,
  input  logic                       arst_n,
  input  logic [per_map_pkg::AW-1:0] per_addr,    // Word address
  input  logic [per_map_pkg::DW-1:0] per_din,
  input  logic                       per_en,
  input  logic [1:0]                 per_we,      // Byte strobes
  output logic [per_map_pkg::DW-1:0] per_dout,
  input  logic [7:0]                 p1_din,      // Asynchronous pins
  output logic [7:0]                 p1_dout,
  output logic [7:0]                 p1_dout_en,
  output logic                       uart_txd,
  output logic [irq_pkg::IRQ_W-1:0]  irq_out
);

  logic [per_map_pkg::DW-1:0] per_dout_gpio;
  logic [per_map_pkg::DW-1:0] per_dout_ta;
  logic [per_map_pkg::DW-1:0] per_dout_baud;
  logic [per_map_pkg::DW-1:0] per_dout_utx;
  logic                       irq_port1;
  logic                       irq_ta0;
  logic                       irq_ta1;
  logic                       irq_uart_tx;
  logic                       bit_run;           // Frame in progress
  logic                       bit_tick;          // End of bit period

  gpio_port #(.BASE_ADDR(GPIO_BASE)) u_gpio (
    .mclk, .arst_n, .per_addr, .per_din, .per_en, .per_we,
    .per_dout   (per_dout_gpio),
    .p1_din, .p1_dout, .p1_dout_en,
    .irq_port1
  );

  timer_a #(.BASE_ADDR(TA_BASE)) u_ta (
    .mclk, .arst_n, .per_addr, .per_din, .per_en, .per_we,
    .per_dout   (per_dout_ta),
    .irq_ta0, .irq_ta1
  );

  uart_baud_gen #(.BASE_ADDR(UART_BASE), .RST_BAUD(RST_BAUD)) u_baud (
    .mclk, .arst_n, .per_addr, .per_din, .per_en, .per_we,
    .bit_run,
    .per_dout   (per_dout_baud),
    .bit_tick
  );

  uart_tx_fsm #(.BASE_ADDR(UART_BASE)) u_utx (
    .mclk, .arst_n, .per_addr, .per_din, .per_en, .per_we,
    .bit_tick,
    .per_dout   (per_dout_utx),
    .bit_run, .uart_txd, .irq_uart_tx
  );

  //------------------------------------------------
  // Read bus and interrupt vector
  //------------------------------------------------
  assign per_dout = per_dout_gpio | per_dout_ta  // Unselected blocks drive zero
                  | per_dout_baud | per_dout_utx;

  always_comb begin
    irq_out                       = '0;          // Unused vectors
    irq_out[irq_pkg::VEC_PORT1]   = irq_port1;
    irq_out[irq_pkg::VEC_UART_TX] = irq_uart_tx;
    irq_out[irq_pkg::VEC_TA1]     = irq_ta1;
    irq_out[irq_pkg::VEC_TA0]     = irq_ta0;
  end

endmodule

// ==== design/timer_a.sv ====
//------------------------------------------------
// Timer A, up mode only
// TACTL, TACCTL0, TACCR0, input divider,
// TAR counter and the two timer interrupts
//------------------------------------------------
module timer_a #(
  parameter logic [15:0] BASE_ADDR = per_map_pkg::TA_BASE_DEF
) (
  input  logic                       mclk,
  input  logic                       arst_n,
  input  logic [per_map_pkg::AW-1:0] per_addr,
  input  logic [per_map_pkg::DW-1:0] per_din,
  input  logic                       per_en,
  input  logic [1:0]                 per_we,
  output logic [per_map_pkg::DW-1:0] per_dout,
  output logic                       irq_ta0,
  output logic                       irq_ta1
);

  per_map_pkg::per_word_u din_u;
  logic [1:0]  wr_tactl;
  logic [1:0]  wr_cctl;
  logic [1:0]  wr_tar;
  logic [1:0]  wr_ccr0;
  logic        rd_en;
  logic [1:0]  id;                               // Divider select
  logic        mc_up;
  logic        taie;
  logic        taifg;
  logic        ccie;
  logic        ccifg;
  logic [15:0] taccr0;
  logic [15:0] tar;
  logic [2:0]  div_cnt;
  logic [2:0]  div_mask;
  logic        div_strobe;                       // TAR advance
  logic        taclr;
  logic        tar_wrap;

  assign din_u.word = per_din;
  assign wr_tactl = per_we & {2{per_en & per_map_pkg::reg_hit(per_addr, BASE_ADDR,
                                                              per_map_pkg::OFS_TACTL)}};
  assign wr_cctl  = per_we & {2{per_en & per_map_pkg::reg_hit(per_addr, BASE_ADDR,
                                                              per_map_pkg::OFS_TACCTL0)}};
  assign wr_tar   = per_we & {2{per_en & per_map_pkg::reg_hit(per_addr, BASE_ADDR,
                                                              per_map_pkg::OFS_TAR)}};
  assign wr_ccr0  = per_we & {2{per_en & per_map_pkg::reg_hit(per_addr, BASE_ADDR,
                                                              per_map_pkg::OFS_TACCR0)}};
  assign rd_en    = per_en & (per_we == 2'b00);

  assign taclr      = wr_tactl[0] & din_u.lane.lo[per_map_pkg::TACLR]; // Self-clearing
  assign div_mask   = 3'b111 >> (2'd3 - id);     // 0, 1, 3, 7
  assign div_strobe = mc_up & ((div_cnt & div_mask) == div_mask);
  assign tar_wrap   = div_strobe & (tar == taccr0);

  //------------------------------------------------
  // Divider and counter
  //------------------------------------------------
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
      tar     <= '0;
    end else if (taclr) begin
      div_cnt <= '0;
      tar     <= '0;
    end else begin
      if (mc_up) div_cnt <= div_cnt + 3'd1;      // Free running while counting
      if (wr_tar != 2'b00) begin
        if (wr_tar[0]) tar[7:0] <= din_u.lane.lo;
        if (wr_tar[1]) tar[15:8] <= din_u.lane.hi;
      end else if (tar_wrap) begin
        tar <= '0;                               // Up mode rollover at TACCR0
      end else if (div_strobe) begin
        tar <= tar + 16'd1;
      end
    end
  end

  // Control, compare and flags
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      id     <= '0;
      mc_up  <= 1'b0;
      taie   <= 1'b0;
      taifg  <= 1'b0;
      ccie   <= 1'b0;
      ccifg  <= 1'b0;
      taccr0 <= '0;
    end else begin
      if (wr_tactl[0]) begin
        id    <= din_u.lane.lo[per_map_pkg::ID_LSB +: 2];
        mc_up <= din_u.lane.lo[per_map_pkg::MC_UP];
        taie  <= din_u.lane.lo[per_map_pkg::TAIE];
        taifg <= din_u.lane.lo[per_map_pkg::TAIFG];
      end
      if (wr_cctl[0]) begin
        ccie  <= din_u.lane.lo[per_map_pkg::CCIE];
        ccifg <= din_u.lane.lo[per_map_pkg::CCIFG];
      end
      if (tar_wrap) begin                        // Set beats a clearing write
        taifg <= 1'b1;
        ccifg <= 1'b1;
      end
      if (wr_ccr0[0]) taccr0[7:0] <= din_u.lane.lo;
      if (wr_ccr0[1]) taccr0[15:8] <= din_u.lane.hi;
    end
  end

  assign irq_ta0 = ccie & ccifg;
  assign irq_ta1 = taie & taifg;

  always_comb begin
    per_dout = '0;
    if (rd_en && per_map_pkg::reg_hit(per_addr, BASE_ADDR, per_map_pkg::OFS_TACTL))
      per_dout = {8'h00, id, 1'b0, mc_up, 2'b00, taie, taifg};
    if (rd_en && per_map_pkg::reg_hit(per_addr, BASE_ADDR, per_map_pkg::OFS_TACCTL0))
      per_dout = {11'h000, ccie, 3'b000, ccifg};
    if (rd_en && per_map_pkg::reg_hit(per_addr, BASE_ADDR, per_map_pkg::OFS_TAR))
      per_dout = tar;
    if (rd_en && per_map_pkg::reg_hit(per_addr, BASE_ADDR, per_map_pkg::OFS_TACCR0))
      per_dout = taccr0;
  end

  // Divided clock gives isolated strobes
  a_div_gap : assert property (@(posedge mclk) disable iff (!arst_n)
    (div_strobe && id != 2'd0 && wr_tactl == 2'b00) |=> !div_strobe);

endmodule

// ==== design/uart_baud_gen.sv ====
//------------------------------------------------
// UART baud generator
// UBAUD register and bit-period counter
//------------------------------------------------
module uart_baud_gen #(
  parameter logic [15:0] BASE_ADDR = per_map_pkg::UART_BASE_DEF,
  parameter logic [15:0] RST_BAUD  = 16'd7
) (
  input  logic                       mclk,
  input  logic                       arst_n,
  input  logic [per_map_pkg::AW-1:0] per_addr,
  input  logic [per_map_pkg::DW-1:0] per_din,
  input  logic                       per_en,
  input  logic [1:0]                 per_we,
  input  logic                       bit_run,     // High during a frame
  output logic [per_map_pkg::DW-1:0] per_dout,
  output logic                       bit_tick     // Last cycle of a bit
);

  per_map_pkg::per_word_u din_u;
  logic        hit_baud;
  logic [1:0]  wr_baud;
  logic [15:0] baud;                             // Bit period minus one
  logic [15:0] bit_cnt;

  assign din_u.word = per_din;
  assign hit_baud   = per_en & per_map_pkg::reg_hit(per_addr, BASE_ADDR, per_map_pkg::OFS_UBAUD);
  assign wr_baud    = per_we & {2{hit_baud}};
  assign per_dout   = (hit_baud && per_we == 2'b00) ? baud : '0;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      baud <= RST_BAUD;
    end else begin
      if (wr_baud[0]) baud[7:0] <= din_u.lane.lo;
      if (wr_baud[1]) baud[15:8] <= din_u.lane.hi;
    end
  end

  assign bit_tick = bit_run & (bit_cnt == baud);

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) bit_cnt <= '0;
    else if (!bit_run || bit_tick) bit_cnt <= '0; // Held at zero between frames
    else bit_cnt <= bit_cnt + 16'd1;
  end

  // Frames end on a tick, so the count is parked outside a frame
  a_cnt_parked : assert property (@(posedge mclk) disable iff (!arst_n)
    !bit_run |-> (bit_cnt == '0));

endmodule

// ==== design/uart_tx_fsm.sv ====
//------------------------------------------------
// UART transmitter, 8N1
// Control and status registers, TX state machine,
// shift register and transmit interrupt
//------------------------------------------------
module uart_tx_fsm #(
  parameter logic [15:0] BASE_ADDR = per_map_pkg::UART_BASE_DEF
) (
  input  logic                       mclk,
  input  logic                       arst_n,
  input  logic [per_map_pkg::AW-1:0] per_addr,
  input  logic [per_map_pkg::DW-1:0] per_din,
  input  logic                       per_en,
  input  logic [1:0]                 per_we,
  input  logic                       bit_tick,
  output logic [per_map_pkg::DW-1:0] per_dout,
  output logic                       bit_run,
  output logic                       uart_txd,
  output logic                       irq_uart_tx
);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_e;

  per_map_pkg::per_word_u din_u;
  tx_state_e  state;
  logic       hit_ctl;
  logic [1:0] wr_ctl;
  logic       wr_txd;
  logic       tx_start;
  logic       uart_en;
  logic       tx_ie;
  logic       tx_busy;
  logic       tx_done;
  logic [2:0] bit_idx;                           // Data bit number
  logic [7:0] shift;

  assign din_u.word = per_din;
  assign hit_ctl  = per_en & per_map_pkg::reg_hit(per_addr, BASE_ADDR, per_map_pkg::OFS_UCTL_STAT);
  assign wr_ctl   = per_we & {2{hit_ctl}};
  assign wr_txd   = per_en & per_we[0] &
                    per_map_pkg::reg_hit(per_addr, BASE_ADDR, per_map_pkg::OFS_UTXD);
  assign tx_start = wr_txd & uart_en & (state == IDLE); // Busy writes dropped
  assign tx_busy  = (state != IDLE);
  assign bit_run  = tx_busy;

  //------------------------------------------------
  // Control and done flag
  //------------------------------------------------
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      uart_en <= 1'b0;
      tx_ie   <= 1'b0;
      tx_done <= 1'b0;
    end else begin
      if (wr_ctl[0]) begin
        uart_en <= din_u.lane.lo[0];
        tx_ie   <= din_u.lane.lo[3];
      end
      if (wr_ctl[1]) tx_done <= din_u.lane.hi[3]; // Bit 11, write 0 clears
      if (state == STOP && bit_tick) tx_done <= 1'b1;
    end
  end

  // Frame sequencer
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      bit_idx  <= '0;
      uart_txd <= 1'b1;                          // Line idles high
    end else begin
      case (state)
        IDLE: if (tx_start) begin
          state    <= START;
          uart_txd <= 1'b0;                      // Start bit
        end
        START: if (bit_tick) begin
          state    <= DATA;
          bit_idx  <= '0;
          uart_txd <= shift[0];                  // LSB first
        end
        DATA: if (bit_tick) begin
          if (bit_idx == 3'd7) begin
            state    <= STOP;
            uart_txd <= 1'b1;                    // Stop bit
          end else begin
            bit_idx  <= bit_idx + 3'd1;
            uart_txd <= shift[1];
          end
        end
        STOP: if (bit_tick) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge mclk) begin
    if (tx_start) shift <= din_u.lane.lo;
    else if (state == DATA && bit_tick) shift <= shift >> 1;
  end

  assign irq_uart_tx = tx_done & tx_ie;
  assign per_dout    = (hit_ctl && per_we == 2'b00) ?
                       {4'h0, tx_done, 2'b00, tx_busy, 4'h0, tx_ie, 2'b00, uart_en} : '0;

  a_idle_high : assert property (@(posedge mclk) disable iff (!arst_n)
    (state == IDLE) |-> uart_txd);

endmodule

// ==== tb.f ====
+incdir+tests
design/per_map_pkg.sv
design/irq_pkg.sv
design/gpio_port.sv
design/timer_a.sv
design/uart_baud_gen.sv
design/uart_tx_fsm.sv
design/periph_top.sv
tests/tb_top.sv

// ==== tests/tb_bus_tasks.svh ====
//------------------------------------------------
// Testbench bus and UART helpers
// Word write, word read, vector wait and
// UART frame capture at mid-bit
//------------------------------------------------
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// One write cycle, lanes picked by we
task automatic write_word(input logic [15:0] byte_addr, input logic [15:0] data,
                          input logic [1:0] we);
  @(negedge mclk);
  per_addr = byte_addr[14:1];                    // Byte to word address
  per_din  = data;
  per_en   = 1'b1;
  per_we   = we;
  @(negedge mclk);
  per_en   = 1'b0;
  per_we   = 2'b00;
endtask

// One read cycle, data sampled mid low phase
task automatic read_word(input logic [15:0] byte_addr, output logic [15:0] data);
  @(negedge mclk);
  per_addr = byte_addr[14:1];
  per_en   = 1'b1;
  per_we   = 2'b00;
  #1;
  data     = per_dout;                           // Combinational read path
  @(negedge mclk);
  per_en   = 1'b0;
endtask

// Blocks until an interrupt vector bit is high
task automatic wait_vector(input int vec);
  while (irq_out[vec] !== 1'b1) @(negedge mclk);
endtask

// Sample uart_txd in the middle of each bit of one 8N1 frame
task automatic capture_frame(output logic [7:0] data, output logic ok,
                             output int unsigned start_cyc);
  logic start_bit;
  logic stop_bit;
  while (uart_txd === 1'b1) @(negedge mclk);     // Falling start edge
  start_cyc = cyc;
  repeat ((BAUD + 1) / 2 - 1) @(negedge mclk);   // Half a bit in
  start_bit = uart_txd;
  for (int i = 0; i < 8; i++) begin
    repeat (BAUD + 1) @(negedge mclk);
    data[i] = uart_txd;                          // LSB first
  end
  repeat (BAUD + 1) @(negedge mclk);
  stop_bit = uart_txd;
  ok = (start_bit === 1'b0) && (stop_bit === 1'b1);
endtask

`endif

// ==== tests/tb_top.sv ====
//------------------------------------------------
// Peripheral subsystem testbench
// Clock, reset, DUT, watchdog, GPIO, Timer A
// and UART sequences, checks and final report
//------------------------------------------------
module tb_top;

  localparam logic [15:0] BAUD = 16'd7;
  localparam logic [15:0] GPIO = per_map_pkg::GPIO_BASE_DEF;
  localparam logic [15:0] TA   = per_map_pkg::TA_BASE_DEF;
  localparam logic [15:0] UART = per_map_pkg::UART_BASE_DEF;
  localparam logic [irq_pkg::IRQ_W-1:0] IRQ_USED =
    (14'd1 << irq_pkg::VEC_PORT1) | (14'd1 << irq_pkg::VEC_UART_TX) |
    (14'd1 << irq_pkg::VEC_TA1) | (14'd1 << irq_pkg::VEC_TA0);

  logic                          mclk;
  logic                          arst_n;
  logic [per_map_pkg::AW-1:0]    per_addr;
  logic [per_map_pkg::DW-1:0]    per_din;
  logic                          per_en;
  logic [1:0]                    per_we;
  logic [per_map_pkg::DW-1:0]    per_dout;
  logic [7:0]                    p1_din;
  logic [7:0]                    p1_dout;
  logic [7:0]                    p1_dout_en;
  logic                          uart_txd;
  logic [irq_pkg::IRQ_W-1:0]     irq_out;
  int unsigned cyc = 0;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned limit;
  int unsigned period;
  int unsigned t0;
  int unsigned t_frame;
  logic [15:0] rd;
  logic [15:0] tacc_n;
  logic [7:0]  out_v;
  logic [7:0]  dir_v;
  logic [7:0]  ies_v;
  logic [7:0]  ie_v;
  logic [7:0]  old_p;
  logic [7:0]  new_p;
  logic [7:0]  exp_ifg;
  logic [7:0]  tx_byte;
  logic [7:0]  rx_byte;
  logic        frame_ok;
  logic        saw_low;
  int          bit_sel;

  periph_top #(.RST_BAUD(BAUD)) u_dut (.*);

  `include "tb_bus_tasks.svh"

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  initial begin
    mclk = 1'b0;
    forever #5 mclk = ~mclk;
  end

  always @(posedge mclk) cyc <= cyc + 1;

  // Vector bits with no source stay low
  a_irq_unused : assert property (@(posedge mclk) disable iff (!arst_n)
    (irq_out & ~IRQ_USED) == '0) else begin
    errors++;
    $display("Error: irq_out got %h outside mask %h", irq_out, IRQ_USED);
  end

  initial begin
    void'($urandom(32'h631bd80f));
    arst_n   = 1'b0;
    per_addr = '0;
    per_din  = '0;
    per_en   = 1'b0;
    per_we   = 2'b00;
    p1_din   = $urandom;
    tacc_n   = 16'd3 + ($urandom % 6);           // TACCR0 from 3 to 8
    period   = (tacc_n + 1) * 4;                 // ID = /4
    limit    = 10 * 10 * (BAUD + 1) + 4 * period + 200;
    fork
      begin
        repeat (limit) @(posedge mclk);
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
      end
    join_none
    repeat (3) @(negedge mclk);
    arst_n = 1'b1;
    repeat (4) @(negedge mclk);                  // Let the pin sync settle
    write_word(GPIO + per_map_pkg::OFS_P1DIR_IFG, 16'h0000, 2'b10); // Flags from first sync

    //------------------------------------------------
    // GPIO output path and byte lanes
    //------------------------------------------------
    out_v = $urandom;
    dir_v = $urandom;
    write_word(GPIO + per_map_pkg::OFS_P1IN_OUT, {out_v, 8'hA5}, 2'b10);
    check_value("p1_dout", p1_dout, out_v);
    write_word(GPIO + per_map_pkg::OFS_P1DIR_IFG, {8'hFF, dir_v}, 2'b01);
    check_value("p1_dout_en", p1_dout_en, dir_v);
    read_word(GPIO + per_map_pkg::OFS_P1IN_OUT, rd);
    check_value("P1IN_OUT", rd, {out_v, p1_din});
    read_word(GPIO + per_map_pkg::OFS_P1DIR_IFG, rd);
    check_value("P1DIR_IFG", rd, {8'h00, dir_v}); // IFG lane untouched
    ie_v  = $urandom;
    ies_v = $urandom;
    write_word(GPIO + per_map_pkg::OFS_P1IES_IE, {ie_v, ies_v}, 2'b11);
    write_word(GPIO + per_map_pkg::OFS_P1IES_IE, {~ie_v, ~ies_v}, 2'b01);
    read_word(GPIO + per_map_pkg::OFS_P1IES_IE, rd);
    check_value("P1IES_IE", rd, {ie_v, ~ies_v});

    // GPIO edge interrupt
    old_p   = p1_din;
    bit_sel = $urandom % 8;
    ies_v   = $urandom;
    ies_v[bit_sel] = old_p[bit_sel];             // Edge on this bit must count
    new_p   = $urandom;
    new_p[bit_sel] = ~old_p[bit_sel];
    exp_ifg = (new_p & ~old_p & ~ies_v) | (~new_p & old_p & ies_v);
    write_word(GPIO + per_map_pkg::OFS_P1IES_IE, {8'hFF, ies_v}, 2'b11);
    write_word(GPIO + per_map_pkg::OFS_P1DIR_IFG, 16'h0000, 2'b10);
    check_value("irq_out[VEC_PORT1]", irq_out[irq_pkg::VEC_PORT1], 1'b0);
    @(negedge mclk);
    p1_din = new_p;
    repeat (3) @(negedge mclk);
    check_value("irq_out[VEC_PORT1]", irq_out[irq_pkg::VEC_PORT1], 1'b0);
    @(negedge mclk);                             // Flag one cycle after P1IN
    check_value("irq_out[VEC_PORT1]", irq_out[irq_pkg::VEC_PORT1], 1'b1);
    read_word(GPIO + per_map_pkg::OFS_P1DIR_IFG, rd);
    check_value("P1IFG", rd[15:8], exp_ifg);
    write_word(GPIO + per_map_pkg::OFS_P1DIR_IFG, 16'h0000, 2'b10);
    check_value("irq_out[VEC_PORT1]", irq_out[irq_pkg::VEC_PORT1], 1'b0);
    read_word(GPIO + per_map_pkg::OFS_P1DIR_IFG, rd);
    check_value("P1IFG", rd[15:8], 8'h00);

    //------------------------------------------------
    // Timer A up mode, divide by 4
    //------------------------------------------------
    write_word(TA + per_map_pkg::OFS_TACCR0, tacc_n, 2'b11);
    write_word(TA + per_map_pkg::OFS_TACCTL0, 16'h0010, 2'b01);       // CCIE
    write_word(TA + per_map_pkg::OFS_TACTL, 16'h0084, 2'b01);         // ID=2, TACLR
    write_word(TA + per_map_pkg::OFS_TACTL, 16'h0092, 2'b01);         // MC_UP, TAIE
    t0 = cyc;
    wait_vector(irq_pkg::VEC_TA0);
    check_value("first CCIFG delay", cyc - t0, period);
    check_value("irq_out[VEC_TA1]", irq_out[irq_pkg::VEC_TA1], 1'b1);
    t0 = cyc;
    write_word(TA + per_map_pkg::OFS_TACCTL0, 16'h0010, 2'b01);       // Clear CCIFG
    write_word(TA + per_map_pkg::OFS_TACTL, 16'h0092, 2'b01);         // Clear TAIFG
    check_value("irq_out[VEC_TA0]", irq_out[irq_pkg::VEC_TA0], 1'b0);
    check_value("irq_out[VEC_TA1]", irq_out[irq_pkg::VEC_TA1], 1'b0);
    wait_vector(irq_pkg::VEC_TA0);
    check_value("CCIFG period", cyc - t0, period);
    repeat (period) begin
      read_word(TA + per_map_pkg::OFS_TAR, rd);
      checks++;
      assert (rd <= tacc_n) else begin
        errors++;
        $display("Error: TAR got %h above TACCR0 %h", rd, tacc_n);
      end
    end
    write_word(TA + per_map_pkg::OFS_TACCTL0, 16'h0001, 2'b01);       // Flag, no CCIE
    check_value("irq_out[VEC_TA0]", irq_out[irq_pkg::VEC_TA0], 1'b0);
    write_word(TA + per_map_pkg::OFS_TACCTL0, 16'h0011, 2'b01);
    check_value("irq_out[VEC_TA0]", irq_out[irq_pkg::VEC_TA0], 1'b1);
    write_word(TA + per_map_pkg::OFS_TACTL, 16'h0091, 2'b01);         // TAIFG, no TAIE
    check_value("irq_out[VEC_TA1]", irq_out[irq_pkg::VEC_TA1], 1'b0);
    write_word(TA + per_map_pkg::OFS_TACTL, 16'h0004, 2'b01);         // Stop and clear
    write_word(TA + per_map_pkg::OFS_TACCTL0, 16'h0000, 2'b01);
    check_value("irq_out[VEC_TA0]", irq_out[irq_pkg::VEC_TA0], 1'b0);
    check_value("irq_out[VEC_TA1]", irq_out[irq_pkg::VEC_TA1], 1'b0);

    //------------------------------------------------
    // UART frame, busy, done and read bus
    //------------------------------------------------
    write_word(UART + per_map_pkg::OFS_UBAUD, BAUD, 2'b11);
    read_word(UART + per_map_pkg::OFS_UBAUD, rd);
    check_value("UBAUD", rd, BAUD);
    write_word(UART + per_map_pkg::OFS_UCTL_STAT, 16'h0009, 2'b01);   // Enable, TX IE
    tx_byte = $urandom;
    fork
      capture_frame(rx_byte, frame_ok, t_frame);
      begin
        write_word(UART + per_map_pkg::OFS_UTXD, {8'h00, tx_byte}, 2'b01);
        read_word(UART + per_map_pkg::OFS_UCTL_STAT, rd);
        check_value("UART status", rd, 16'h0109);                     // tx_busy set
        write_word(UART + per_map_pkg::OFS_UTXD, {8'h00, ~tx_byte}, 2'b01);
      end
    join
    checks++;
    assert (frame_ok) else begin
      errors++;
      $display("UART frame had a wrong start or stop bit");
    end
    check_value("uart_txd data", rx_byte, tx_byte);
    wait_vector(irq_pkg::VEC_UART_TX);
    check_value("UART frame length", cyc - t_frame, 10 * (BAUD + 1));
    read_word(UART + per_map_pkg::OFS_UCTL_STAT, rd);
    check_value("UART status", rd, 16'h0809);                         // Done, not busy
    saw_low = 1'b0;
    repeat (2 * (BAUD + 1)) begin
      @(negedge mclk);
      if (uart_txd !== 1'b1) saw_low = 1'b1;
    end
    checks++;
    assert (!saw_low) else begin
      errors++;
      $display("Write during a frame started a second frame");
    end
    write_word(UART + per_map_pkg::OFS_UCTL_STAT, 16'h0000, 2'b10);   // Clear tx_done
    check_value("irq_out[VEC_UART_TX]", irq_out[irq_pkg::VEC_UART_TX], 1'b0);
    read_word(UART + per_map_pkg::OFS_UCTL_STAT, rd);
    check_value("UART status", rd, 16'h0009);
    read_word(GPIO + 16'h0006, rd);
    check_value("unmapped GPIO+6", rd, 16'h0000);
    read_word(TA + 16'h0004, rd);
    check_value("unmapped TA+4", rd, 16'h0000);
    read_word(UART + 16'h0006, rd);
    check_value("unmapped UART+6", rd, 16'h0000);
    read_word(16'h0100, rd);
    check_value("unmapped 0x0100", rd, 16'h0000);

    @(negedge mclk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
